// ==== build.f ====
+incdir+source
source/riscv_isa_pkg.sv
source/id_stage_pkg.sv
source/compressed_expander.sv
source/instr_decoder.sv
source/issue_register.sv
source/id_stage.sv
dv/id_stage_checker.sv
dv/id_stage_tb.sv

// ==== dv/id_stage_checker.sv ====
// Bound assertion checker for handshake, flush and decode flags of the decode stage

`default_nettype none

module id_stage_checker (
  input wire logic              clk_i,
  input wire logic              rst_ni,
  input wire logic              flush_i,
  input wire logic              fetch_valid_i,
  input wire logic [31:0]       fetch_instr_i,
  input wire logic [31:0]       fetch_pc_i,
  input wire logic              issue_ack_i,
  input wire logic              fetch_ready_o,
  input wire logic              issue_valid_o,
  input wire id_stage_pkg::fu_e issue_fu_o,
  input wire id_stage_pkg::op_e issue_op_o,
  input wire logic [4:0]        issue_rd_o,
  input wire logic [4:0]        issue_rs1_o,
  input wire logic [4:0]        issue_rs2_o,
  input wire logic [31:0]       issue_imm_o,
  input wire logic [31:0]       issue_pc_o,
  input wire logic [31:0]       issue_orig_instr_o,
  input wire logic              issue_illegal_o,
  input wire logic              issue_ctrl_flow_o,
  input wire logic              issue_compressed_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failure record that the testbench reads
  logic        fail_flag = 1'b0;
  string       fail_name = "";
  logic [31:0] fail_got  = '0;
  logic [31:0] fail_exp  = '0;

  // One-entry model of the accepted word
  logic [31:0] model_pc;
  logic [31:0] model_instr;
  logic        accept;
  logic        full_word;

  assign accept    = fetch_valid_i & fetch_ready_o;
  assign full_word = (issue_orig_instr_o[1:0] == 2'b11);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      model_pc    <= fetch_pc_i;
      model_instr <= fetch_instr_i;
    end
  end

  function automatic void note_fail(string name, logic [31:0] got, logic [31:0] exp);
    if (!fail_flag) begin
      fail_flag = 1'b1;
      fail_name = name;
      fail_got  = got;
      fail_exp  = exp;
    end
  endfunction

  // --------------------------------------------------
  // Reference rules taken from the RV32I encoding
  // --------------------------------------------------
  function automatic logic full_illegal(logic [31:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:0])
      riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC, riscv_isa_pkg::OPC_JAL: return 1'b0;
      riscv_isa_pkg::OPC_JALR:   return f3 != 3'b000;
      riscv_isa_pkg::OPC_BRANCH: return f3 == 3'b010 || f3 == 3'b011;
      riscv_isa_pkg::OPC_LOAD:   return f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111;
      riscv_isa_pkg::OPC_STORE:  return f3 > 3'b010;
      riscv_isa_pkg::OPC_OP_IMM: begin
        if (f3 == 3'b001) return f7 != 7'h00;
        if (f3 == 3'b101) return f7 != 7'h00 && f7 != 7'h20;
        return 1'b0;
      end
      riscv_isa_pkg::OPC_OP: begin
        if (f7 == 7'h00) return 1'b0;
        return !(f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      end
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic has_dest(logic [31:0] w);
    return w[6:0] inside {riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC,
                          riscv_isa_pkg::OPC_JAL, riscv_isa_pkg::OPC_JALR,
                          riscv_isa_pkg::OPC_LOAD, riscv_isa_pkg::OPC_OP_IMM,
                          riscv_isa_pkg::OPC_OP};
  endfunction

  function automatic logic has_rs1(logic [31:0] w);
    return w[6:0] inside {riscv_isa_pkg::OPC_JALR, riscv_isa_pkg::OPC_BRANCH,
                          riscv_isa_pkg::OPC_LOAD, riscv_isa_pkg::OPC_STORE,
                          riscv_isa_pkg::OPC_OP_IMM, riscv_isa_pkg::OPC_OP};
  endfunction

  function automatic logic has_rs2(logic [31:0] w);
    return w[6:0] inside {riscv_isa_pkg::OPC_BRANCH, riscv_isa_pkg::OPC_STORE,
                          riscv_isa_pkg::OPC_OP};
  endfunction

  // Jumps and branches including C.J, C.BEQZ and C.BNEZ
  function automatic logic is_ctrl(logic [31:0] w);
    if (w[1:0] == 2'b11) begin
      return w[6:0] inside {riscv_isa_pkg::OPC_JAL, riscv_isa_pkg::OPC_JALR,
                            riscv_isa_pkg::OPC_BRANCH};
    end
    return w[1:0] == 2'b01 && w[15:13] inside {3'b101, 3'b110, 3'b111};
  endfunction

  // --------------------------------------------------
  // Handshake and flush
  // --------------------------------------------------
  a_reset_empty: assert property (@(posedge clk_i) $rose(rst_ni) |-> !issue_valid_o)
    else begin
      $error("entry valid after reset");
      note_fail("issue_valid_o", 1, 0);
    end

  a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && !flush_i |=> issue_valid_o)
    else begin
      $error("accepted fetch not visible");
      note_fail("issue_valid_o", 0, 1);
    end

  a_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o |-> issue_pc_o == model_pc)
    else begin
      $error("pc mismatch");
      note_fail("issue_pc_o", issue_pc_o, model_pc);
    end

  a_instr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o |-> issue_orig_instr_o == model_instr)
    else begin
      $error("instruction mismatch");
      note_fail("issue_orig_instr_o", issue_orig_instr_o, model_instr);
    end

  a_stall_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ack_i |-> !fetch_ready_o)
    else begin
      $error("ready while stalled");
      note_fail("fetch_ready_o", 1, 0);
    end

  a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ack_i && !flush_i |=>
      issue_valid_o && $stable(issue_pc_o) && $stable(issue_orig_instr_o) &&
      $stable(issue_imm_o) && $stable(issue_rd_o) && $stable(issue_rs1_o) &&
      $stable(issue_rs2_o) && $stable(issue_fu_o) && $stable(issue_op_o) &&
      $stable(issue_illegal_o) && $stable(issue_ctrl_flow_o) && $stable(issue_compressed_o))
    else begin
      $error("entry changed while stalled");
      note_fail("issue_entry", 1, 0);
    end

  a_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !issue_valid_o)
    else begin
      $error("entry survived flush");
      note_fail("issue_valid_o", 1, 0);
    end

  // --------------------------------------------------
  // Decode flags
  // --------------------------------------------------
  a_compressed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o |-> issue_compressed_o == !full_word)
    else begin
      $error("compressed flag wrong");
      note_fail("issue_compressed_o", issue_compressed_o, !full_word);
    end

  a_rd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && full_word && has_dest(issue_orig_instr_o) |->
      issue_rd_o == issue_orig_instr_o[11:7])
    else begin
      $error("rd wrong");
      note_fail("issue_rd_o", issue_rd_o, issue_orig_instr_o[11:7]);
    end

  a_rs1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && full_word && has_rs1(issue_orig_instr_o) |->
      issue_rs1_o == issue_orig_instr_o[19:15])
    else begin
      $error("rs1 wrong");
      note_fail("issue_rs1_o", issue_rs1_o, issue_orig_instr_o[19:15]);
    end

  a_rs2: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && full_word && has_rs2(issue_orig_instr_o) |->
      issue_rs2_o == issue_orig_instr_o[24:20])
    else begin
      $error("rs2 wrong");
      note_fail("issue_rs2_o", issue_rs2_o, issue_orig_instr_o[24:20]);
    end

  a_illegal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && full_word |-> issue_illegal_o == full_illegal(issue_orig_instr_o))
    else begin
      $error("illegal flag wrong");
      note_fail("issue_illegal_o", issue_illegal_o, full_illegal(issue_orig_instr_o));
    end

  a_illegal_fu: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && issue_illegal_o |-> issue_fu_o == id_stage_pkg::FU_NONE)
    else begin
      $error("illegal entry has a unit");
      note_fail("issue_fu_o", issue_fu_o, 0);
    end

  a_ctrl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o |-> issue_ctrl_flow_o == is_ctrl(issue_orig_instr_o))
    else begin
      $error("control flow flag wrong");
      note_fail("issue_ctrl_flow_o", issue_ctrl_flow_o, is_ctrl(issue_orig_instr_o));
    end

endmodule

`default_nettype wire

// ==== dv/id_stage_tb.sv ====
// Testbench for the decode stage: clock, reset, directed and random stimulus

`default_nettype none

module id_stage_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 200;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_instr_i;
  logic [31:0] fetch_pc_i;
  logic        issue_ack_i;
  logic        fetch_ready_o;
  logic        issue_valid_o;
  logic [4:0]  issue_rd_o;
  logic [4:0]  issue_rs1_o;
  logic [4:0]  issue_rs2_o;
  logic [31:0] issue_imm_o;
  logic [31:0] issue_pc_o;
  logic [31:0] issue_orig_instr_o;
  logic        issue_illegal_o;
  logic        issue_ctrl_flow_o;
  logic        issue_compressed_o;
  id_stage_pkg::fu_e issue_fu_o;
  id_stage_pkg::op_e issue_op_o;

  integer seed = 32'h41a4;
  logic   flush_en;

  id_stage UUT (.*);

  bind id_stage id_stage_checker u_checker (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic fail_value(string name, logic [31:0] got, logic [31:0] exp);
    $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    $display("Result: FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic fail_timeout(string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Result: FAILED");
    $fatal(1, "timeout");
  endtask

  // Checker failures surface here
  always @(negedge clk_i) begin
    if (UUT.u_checker.fail_flag) begin
      fail_value(UUT.u_checker.fail_name, UUT.u_checker.fail_got, UUT.u_checker.fail_exp);
    end
  end

  // Random ack and, when enabled, occasional flush
  initial begin
    logic [31:0] r;
    forever begin
      @(negedge clk_i);
      r = $random(seed);
      issue_ack_i = (r[1:0] != 2'b00);
      flush_i     = flush_en & (r[5:3] == 3'b000);
    end
  end

  // Offer one word and wait until it is taken
  task automatic send_word(logic [31:0] word, logic [31:0] pc);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    fetch_valid_i = 1'b1;
    fetch_instr_i = word;
    fetch_pc_i    = pc;
    #1;
    while (!fetch_ready_o) begin
      if (cycles == TIMEOUT) begin
        fail_timeout("fetch_ready_o stayed low");
      end
      @(negedge clk_i);
      #1;
      cycles++;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    fetch_valid_i = 1'b0;
  endtask

  // Directed case with expected operation and immediate
  task automatic run_directed(logic [31:0] word, logic check, id_stage_pkg::op_e exp_op,
                              logic [31:0] exp_imm);
    send_word(word, 32'h1000 + word);
    if (check) begin
      assert (issue_valid_o && issue_op_o == exp_op)
        else fail_value("issue_op_o", 32'(issue_op_o), 32'(exp_op));
      assert (issue_imm_o == exp_imm)
        else fail_value("issue_imm_o", issue_imm_o, exp_imm);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] word;
    int          cycles;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    flush_en      = 1'b0;
    issue_ack_i   = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // --------------------------------------------------
    // Compressed forms with expected results
    // --------------------------------------------------
    run_directed(32'h0000_0095, 1'b1, id_stage_pkg::OP_ADD, 32'd5);
    run_directed(32'h0000_517d, 1'b1, id_stage_pkg::OP_ADD, 32'hffff_ffff);
    run_directed(32'h0000_6185, 1'b1, id_stage_pkg::OP_LUI, 32'h0000_1000);
    run_directed(32'h0000_8216, 1'b1, id_stage_pkg::OP_ADD, 32'd0);
    run_directed(32'h0000_9216, 1'b1, id_stage_pkg::OP_ADD, 32'd0);
    run_directed(32'h0000_a021, 1'b1, id_stage_pkg::OP_JAL, 32'd8);
    run_directed(32'h0000_c011, 1'b1, id_stage_pkg::OP_BEQ, 32'd4);
    run_directed(32'h0000_fcfd, 1'b1, id_stage_pkg::OP_BNE, 32'hffff_fffe);
    run_directed(32'h0000_4144, 1'b1, id_stage_pkg::OP_LW, 32'd4);
    run_directed(32'h0000_c60c, 1'b1, id_stage_pkg::OP_SW, 32'd8);
    run_directed(32'h0000_0000, 1'b0, id_stage_pkg::OP_ADD, 32'd0);

    // One of each RV32I group, plus two illegal words
    run_directed(32'h1234_50b7, 1'b1, id_stage_pkg::OP_LUI, 32'h1234_5000);
    run_directed(32'h0000_1117, 1'b1, id_stage_pkg::OP_AUIPC, 32'h0000_1000);
    run_directed(32'h0080_00ef, 1'b1, id_stage_pkg::OP_JAL, 32'd8);
    run_directed(32'h0000_80e7, 1'b1, id_stage_pkg::OP_JALR, 32'd0);
    run_directed(32'h0020_8463, 1'b1, id_stage_pkg::OP_BEQ, 32'd8);
    run_directed(32'h0000_a283, 1'b1, id_stage_pkg::OP_LW, 32'd0);
    run_directed(32'h0050_a023, 1'b1, id_stage_pkg::OP_SW, 32'd0);
    run_directed(32'h0010_0093, 1'b1, id_stage_pkg::OP_ADD, 32'd1);
    run_directed(32'h4020_81b3, 1'b1, id_stage_pkg::OP_SUB, 32'd0);
    run_directed(32'h0000_007f, 1'b0, id_stage_pkg::OP_ADD, 32'd0);
    run_directed(32'h0000_b283, 1'b0, id_stage_pkg::OP_ADD, 32'd0);

    // Random words with back-pressure and flushes
    flush_en = 1'b1;
    for (int i = 0; i < 300; i++) begin
      r    = $random(seed);
      word = r;
      if (r[31]) begin
        word[1:0] = 2'b11;
      end
      send_word(word, 32'(i) * 4);
    end
    flush_en = 1'b0;

    // Drain the last entry
    cycles = 0;
    while (issue_valid_o) begin
      if (cycles == TIMEOUT) begin
        fail_timeout("last entry was never acknowledged");
      end
      @(negedge clk_i);
      cycles++;
    end
    repeat (3) @(negedge clk_i);

    if (UUT.u_checker.fail_flag) begin
      fail_value(UUT.u_checker.fail_name, UUT.u_checker.fail_got, UUT.u_checker.fail_exp);
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage simulation with Verilator

verilator --binary --timing --assert -f build.f --top-module id_stage_tb -o id_stage_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/id_stage_sim > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0

// ==== source/compressed_expander.sv ====
// Compressed instruction expander for the supported RVC subset

`default_nettype none

`include "id_params.svh"

module compressed_expander (
  input  logic [`ID_ILEN-1:0] instr_i,
  output logic [`ID_ILEN-1:0] instr_o,
  output logic                is_compressed_o,
  output logic                illegal_o
);

  logic [4:0]  rd_full;
  logic [4:0]  rs2_full;
  logic [4:0]  rd_prime;
  logic [4:0]  rs1_prime;
  logic [11:0] imm_ci;
  logic [11:0] imm_mem;
  logic [20:0] imm_j;
  logic [12:0] imm_b;

  // Register fields, primed forms address x8..x15
  assign rd_full   = instr_i[11:7];
  assign rs2_full  = instr_i[6:2];
  assign rd_prime  = {2'b01, instr_i[4:2]};
  assign rs1_prime = {2'b01, instr_i[9:7]};

  // --------------------------------------------------
  // Immediates rebuilt from the scattered bits
  // --------------------------------------------------
  assign imm_ci  = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};
  // Word offset, zero extended
  assign imm_mem = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00};
  assign imm_j   = {{9{instr_i[12]}}, instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                    instr_i[7], instr_i[2], instr_i[11], instr_i[5:3], 1'b0};
  assign imm_b   = {{4{instr_i[12]}}, instr_i[12], instr_i[6:5], instr_i[2],
                    instr_i[11:10], instr_i[4:3], 1'b0};

  always_comb begin
    instr_o         = '0;
    is_compressed_o = 1'b1;
    illegal_o       = 1'b0;

    case (riscv_isa_pkg::c_quadrant_e'(instr_i[1:0]))
      riscv_isa_pkg::C_Q0: begin
        case (riscv_isa_pkg::c0_funct3_e'(instr_i[15:13]))
          riscv_isa_pkg::C0_LW: begin
            instr_o = {imm_mem, rs1_prime, 3'b010, rd_prime, riscv_isa_pkg::OPC_LOAD};
          end
          riscv_isa_pkg::C0_SW: begin
            instr_o = {imm_mem[11:5], rd_prime, rs1_prime, 3'b010, imm_mem[4:0],
                       riscv_isa_pkg::OPC_STORE};
          end
          default: illegal_o = 1'b1;
        endcase
      end

      riscv_isa_pkg::C_Q1: begin
        case (riscv_isa_pkg::c1_funct3_e'(instr_i[15:13]))
          riscv_isa_pkg::C1_ADDI: begin
            instr_o = {imm_ci, rd_full, 3'b000, rd_full, riscv_isa_pkg::OPC_OP_IMM};
          end
          riscv_isa_pkg::C1_LI: begin
            instr_o = {imm_ci, 5'd0, 3'b000, rd_full, riscv_isa_pkg::OPC_OP_IMM};
          end
          riscv_isa_pkg::C1_LUI: begin
            instr_o = {{15{instr_i[12]}}, instr_i[6:2], rd_full, riscv_isa_pkg::OPC_LUI};
            // rd of x2 is C.ADDI16SP, and a zero immediate is reserved
            if (rd_full == 5'd2 || imm_ci == '0) begin
              illegal_o = 1'b1;
            end
          end
          riscv_isa_pkg::C1_J: begin
            instr_o = {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12], 5'd0,
                       riscv_isa_pkg::OPC_JAL};
          end
          riscv_isa_pkg::C1_BEQZ, riscv_isa_pkg::C1_BNEZ: begin
            // funct3 000 for BEQ, 001 for BNE
            instr_o = {imm_b[12], imm_b[10:5], 5'd0, rs1_prime, 2'b00, instr_i[13],
                       imm_b[4:1], imm_b[11], riscv_isa_pkg::OPC_BRANCH};
          end
          default: illegal_o = 1'b1;
        endcase
      end

      riscv_isa_pkg::C_Q2: begin
        // rs2 of zero selects the jump and break forms, not supported here
        if (riscv_isa_pkg::c2_funct3_e'(instr_i[15:13]) == riscv_isa_pkg::C2_MV_ADD &&
            rs2_full != 5'd0) begin
          if (instr_i[12]) begin
            instr_o = {7'b0, rs2_full, rd_full, 3'b000, rd_full, riscv_isa_pkg::OPC_OP};
          end else begin
            instr_o = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, riscv_isa_pkg::OPC_OP};
          end
        end else begin
          illegal_o = 1'b1;
        end
      end

      default: begin
        instr_o         = instr_i;
        is_compressed_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/id_params.svh ====
// Instruction decode widths and instruction field positions

`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// Data path, instruction and register file widths
`define ID_XLEN 32
`define ID_ILEN 32
`define ID_REG_AW 5

// Major opcode width
`define ID_OPC_W 7

// --------------------------------------------------
// Field positions in a 32-bit instruction
// --------------------------------------------------
`define ID_RD_LSB 7
`define ID_FUNCT3_LSB 12
`define ID_RS1_LSB 15
`define ID_RS2_LSB 20
`define ID_FUNCT7_LSB 25

`endif

// ==== source/id_stage.sv ====
// Instruction decode stage top level: expander, decoder and issue register

`default_nettype none

`include "id_params.svh"

module id_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  fetch_valid_i,
  input  logic [`ID_ILEN-1:0]   fetch_instr_i,
  input  logic [`ID_XLEN-1:0]   fetch_pc_i,
  input  logic                  issue_ack_i,
  output logic                  fetch_ready_o,
  output logic                  issue_valid_o,
  output id_stage_pkg::fu_e     issue_fu_o,
  output id_stage_pkg::op_e     issue_op_o,
  output logic [`ID_REG_AW-1:0] issue_rd_o,
  output logic [`ID_REG_AW-1:0] issue_rs1_o,
  output logic [`ID_REG_AW-1:0] issue_rs2_o,
  output logic [`ID_XLEN-1:0]   issue_imm_o,
  output logic [`ID_XLEN-1:0]   issue_pc_o,
  output logic [`ID_ILEN-1:0]   issue_orig_instr_o,
  output logic                  issue_illegal_o,
  output logic                  issue_ctrl_flow_o,
  output logic                  issue_compressed_o
);

  logic [`ID_ILEN-1:0]   exp_instr;
  logic                  exp_compressed;
  logic                  exp_illegal;
  id_stage_pkg::fu_e     dec_fu;
  id_stage_pkg::op_e     dec_op;
  logic [`ID_REG_AW-1:0] dec_rd;
  logic [`ID_REG_AW-1:0] dec_rs1;
  logic [`ID_REG_AW-1:0] dec_rs2;
  logic [`ID_XLEN-1:0]   dec_imm;
  logic                  dec_illegal;
  logic                  dec_ctrl_flow;

  compressed_expander u_expander (
    .instr_i         (fetch_instr_i),
    .instr_o         (exp_instr),
    .is_compressed_o (exp_compressed),
    .illegal_o       (exp_illegal)
  );

  instr_decoder u_decoder (
    .instr_i        (exp_instr),
    .illegal_i      (exp_illegal),
    .fu_o           (dec_fu),
    .op_o           (dec_op),
    .rd_o           (dec_rd),
    .rs1_o          (dec_rs1),
    .rs2_o          (dec_rs2),
    .imm_o          (dec_imm),
    .illegal_o      (dec_illegal),
    .is_ctrl_flow_o (dec_ctrl_flow)
  );

  // The entry keeps the fetched word as it arrived
  issue_register u_issue_reg (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .fetch_valid_i   (fetch_valid_i),
    .issue_ack_i     (issue_ack_i),
    .fu_i            (dec_fu),
    .op_i            (dec_op),
    .rd_i            (dec_rd),
    .rs1_i           (dec_rs1),
    .rs2_i           (dec_rs2),
    .imm_i           (dec_imm),
    .pc_i            (fetch_pc_i),
    .orig_instr_i    (fetch_instr_i),
    .illegal_i       (dec_illegal),
    .ctrl_flow_i     (dec_ctrl_flow),
    .is_compressed_i (exp_compressed),
    .fetch_ready_o   (fetch_ready_o),
    .issue_valid_o   (issue_valid_o),
    .fu_o            (issue_fu_o),
    .op_o            (issue_op_o),
    .rd_o            (issue_rd_o),
    .rs1_o           (issue_rs1_o),
    .rs2_o           (issue_rs2_o),
    .imm_o           (issue_imm_o),
    .pc_o            (issue_pc_o),
    .orig_instr_o    (issue_orig_instr_o),
    .illegal_o       (issue_illegal_o),
    .ctrl_flow_o     (issue_ctrl_flow_o),
    .is_compressed_o (issue_compressed_o)
  );

endmodule

`default_nettype wire

// ==== source/id_stage_pkg.sv ====
// Decode result types: functional unit and operation of an issue entry

`default_nettype none

package id_stage_pkg;

  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_BRANCH,
    FU_LOAD,
    FU_STORE,
    FU_CTRL
  } fu_e;

  typedef enum logic [4:0] {
    // Arithmetic and logic
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    // Upper immediates and jumps
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    // Conditional branches
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    // Memory access
    OP_LW, OP_LH, OP_LB, OP_LHU, OP_LBU,
    OP_SW, OP_SH, OP_SB
  } op_e;

endpackage

`default_nettype wire

// ==== source/instr_decoder.sv ====
// RV32I instruction decoder producing the fields of one issue entry

`default_nettype none

`include "id_params.svh"

module instr_decoder (
  input  logic [`ID_ILEN-1:0]   instr_i,
  input  logic                  illegal_i,
  output id_stage_pkg::fu_e     fu_o,
  output id_stage_pkg::op_e     op_o,
  output logic [`ID_REG_AW-1:0] rd_o,
  output logic [`ID_REG_AW-1:0] rs1_o,
  output logic [`ID_REG_AW-1:0] rs2_o,
  output logic [`ID_XLEN-1:0]   imm_o,
  output logic                  illegal_o,
  output logic                  is_ctrl_flow_o
);

  logic [2:0]        funct3;
  logic [6:0]        funct7;
  id_stage_pkg::fu_e fu;
  logic              bad_encoding;
  logic              use_rd;
  logic              use_rs1;
  logic              use_rs2;

  assign funct3 = instr_i[`ID_FUNCT3_LSB +: 3];
  assign funct7 = instr_i[`ID_FUNCT7_LSB +: 7];

  always_comb begin
    fu             = id_stage_pkg::FU_NONE;
    op_o           = id_stage_pkg::OP_ADD;
    imm_o          = '0;
    bad_encoding   = 1'b0;
    is_ctrl_flow_o = 1'b0;
    use_rd         = 1'b0;
    use_rs1        = 1'b0;
    use_rs2        = 1'b0;

    case (riscv_isa_pkg::opcode_e'(instr_i[`ID_OPC_W-1:0]))
      riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC: begin
        fu     = id_stage_pkg::FU_ALU;
        op_o   = instr_i[5] ? id_stage_pkg::OP_LUI : id_stage_pkg::OP_AUIPC;
        imm_o  = {instr_i[31:12], 12'b0};
        use_rd = 1'b1;
      end
      riscv_isa_pkg::OPC_JAL: begin
        fu             = id_stage_pkg::FU_CTRL;
        op_o           = id_stage_pkg::OP_JAL;
        imm_o          = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
        use_rd         = 1'b1;
        is_ctrl_flow_o = 1'b1;
      end
      riscv_isa_pkg::OPC_JALR: begin
        fu             = id_stage_pkg::FU_CTRL;
        op_o           = id_stage_pkg::OP_JALR;
        imm_o          = {{20{instr_i[31]}}, instr_i[31:20]};
        use_rd         = 1'b1;
        use_rs1        = 1'b1;
        is_ctrl_flow_o = 1'b1;
        bad_encoding   = (funct3 != 3'b000);
      end
      riscv_isa_pkg::OPC_BRANCH: begin
        fu             = id_stage_pkg::FU_BRANCH;
        imm_o          = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        is_ctrl_flow_o = 1'b1;
        case (funct3)
          3'b000:  op_o = id_stage_pkg::OP_BEQ;
          3'b001:  op_o = id_stage_pkg::OP_BNE;
          3'b100:  op_o = id_stage_pkg::OP_BLT;
          3'b101:  op_o = id_stage_pkg::OP_BGE;
          3'b110:  op_o = id_stage_pkg::OP_BLTU;
          3'b111:  op_o = id_stage_pkg::OP_BGEU;
          default: bad_encoding = 1'b1;
        endcase
      end
      riscv_isa_pkg::OPC_LOAD: begin
        fu      = id_stage_pkg::FU_LOAD;
        imm_o   = {{20{instr_i[31]}}, instr_i[31:20]};
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        case (funct3)
          3'b000:  op_o = id_stage_pkg::OP_LB;
          3'b001:  op_o = id_stage_pkg::OP_LH;
          3'b010:  op_o = id_stage_pkg::OP_LW;
          3'b100:  op_o = id_stage_pkg::OP_LBU;
          3'b101:  op_o = id_stage_pkg::OP_LHU;
          default: bad_encoding = 1'b1;
        endcase
      end
      riscv_isa_pkg::OPC_STORE: begin
        fu      = id_stage_pkg::FU_STORE;
        imm_o   = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (funct3)
          3'b000:  op_o = id_stage_pkg::OP_SB;
          3'b001:  op_o = id_stage_pkg::OP_SH;
          3'b010:  op_o = id_stage_pkg::OP_SW;
          default: bad_encoding = 1'b1;
        endcase
      end
      riscv_isa_pkg::OPC_OP_IMM: begin
        fu      = id_stage_pkg::FU_ALU;
        imm_o   = {{20{instr_i[31]}}, instr_i[31:20]};
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        case (funct3)
          3'b000: op_o = id_stage_pkg::OP_ADD;
          3'b010: op_o = id_stage_pkg::OP_SLT;
          3'b011: op_o = id_stage_pkg::OP_SLTU;
          3'b100: op_o = id_stage_pkg::OP_XOR;
          3'b110: op_o = id_stage_pkg::OP_OR;
          3'b111: op_o = id_stage_pkg::OP_AND;
          3'b001: begin
            op_o         = id_stage_pkg::OP_SLL;
            bad_encoding = (funct7 != 7'h00);
          end
          default: begin
            // Shift right, bit 30 picks arithmetic
            op_o         = instr_i[30] ? id_stage_pkg::OP_SRA : id_stage_pkg::OP_SRL;
            bad_encoding = (funct7 != 7'h00 && funct7 != 7'h20);
          end
        endcase
      end
      riscv_isa_pkg::OPC_OP: begin
        fu      = id_stage_pkg::FU_ALU;
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: op_o = id_stage_pkg::OP_ADD;
          {7'h20, 3'b000}: op_o = id_stage_pkg::OP_SUB;
          {7'h00, 3'b001}: op_o = id_stage_pkg::OP_SLL;
          {7'h00, 3'b010}: op_o = id_stage_pkg::OP_SLT;
          {7'h00, 3'b011}: op_o = id_stage_pkg::OP_SLTU;
          {7'h00, 3'b100}: op_o = id_stage_pkg::OP_XOR;
          {7'h00, 3'b101}: op_o = id_stage_pkg::OP_SRL;
          {7'h20, 3'b101}: op_o = id_stage_pkg::OP_SRA;
          {7'h00, 3'b110}: op_o = id_stage_pkg::OP_OR;
          {7'h00, 3'b111}: op_o = id_stage_pkg::OP_AND;
          default:         bad_encoding = 1'b1;
        endcase
      end
      default: bad_encoding = 1'b1;
    endcase
  end

  // Unused register fields read as x0
  assign rd_o  = use_rd  ? instr_i[`ID_RD_LSB  +: `ID_REG_AW] : '0;
  assign rs1_o = use_rs1 ? instr_i[`ID_RS1_LSB +: `ID_REG_AW] : '0;
  assign rs2_o = use_rs2 ? instr_i[`ID_RS2_LSB +: `ID_REG_AW] : '0;

  assign illegal_o = illegal_i | bad_encoding;
  assign fu_o      = illegal_o ? id_stage_pkg::FU_NONE : fu;

endmodule

`default_nettype wire

// ==== source/issue_register.sv ====
// Decode to issue pipeline register with fetch ready, ack and flush

`default_nettype none

`include "id_params.svh"

module issue_register (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  fetch_valid_i,
  input  logic                  issue_ack_i,
  input  id_stage_pkg::fu_e     fu_i,
  input  id_stage_pkg::op_e     op_i,
  input  logic [`ID_REG_AW-1:0] rd_i,
  input  logic [`ID_REG_AW-1:0] rs1_i,
  input  logic [`ID_REG_AW-1:0] rs2_i,
  input  logic [`ID_XLEN-1:0]   imm_i,
  input  logic [`ID_XLEN-1:0]   pc_i,
  input  logic [`ID_ILEN-1:0]   orig_instr_i,
  input  logic                  illegal_i,
  input  logic                  ctrl_flow_i,
  input  logic                  is_compressed_i,
  output logic                  fetch_ready_o,
  output logic                  issue_valid_o,
  output id_stage_pkg::fu_e     fu_o,
  output id_stage_pkg::op_e     op_o,
  output logic [`ID_REG_AW-1:0] rd_o,
  output logic [`ID_REG_AW-1:0] rs1_o,
  output logic [`ID_REG_AW-1:0] rs2_o,
  output logic [`ID_XLEN-1:0]   imm_o,
  output logic [`ID_XLEN-1:0]   pc_o,
  output logic [`ID_ILEN-1:0]   orig_instr_o,
  output logic                  illegal_o,
  output logic                  ctrl_flow_o,
  output logic                  is_compressed_o
);

  logic accept;

  // Space exists when empty or when the held entry leaves this cycle
  assign fetch_ready_o = fetch_valid_i & (~issue_valid_o | issue_ack_i);
  assign accept        = fetch_valid_i & fetch_ready_o;

  // --------------------------------------------------
  // Valid bit, flush wins over a new entry
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else if (flush_i) begin
      issue_valid_o <= 1'b0;
    end else if (accept) begin
      issue_valid_o <= 1'b1;
    end else if (issue_ack_i) begin
      issue_valid_o <= 1'b0;
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      fu_o            <= fu_i;
      op_o            <= op_i;
      rd_o            <= rd_i;
      rs1_o           <= rs1_i;
      rs2_o           <= rs2_i;
      imm_o           <= imm_i;
      pc_o            <= pc_i;
      orig_instr_o    <= orig_instr_i;
      illegal_o       <= illegal_i;
      ctrl_flow_o     <= ctrl_flow_i;
      is_compressed_o <= is_compressed_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/riscv_isa_pkg.sv ====
// ISA encodings: RV32I major opcodes and compressed quadrant and funct3 cases

`default_nettype none

`include "id_params.svh"

package riscv_isa_pkg;

  // Major opcodes of the supported RV32I groups
  typedef enum logic [`ID_OPC_W-1:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // Low two bits of a fetched word, 2'b11 marks a full-width instruction
  typedef enum logic [1:0] {
    C_Q0   = 2'b00,
    C_Q1   = 2'b01,
    C_Q2   = 2'b10,
    C_FULL = 2'b11
  } c_quadrant_e;

  // --------------------------------------------------
  // Compressed funct3 cases, one enum per quadrant
  // --------------------------------------------------
  typedef enum logic [2:0] {
    C0_LW = 3'b010,
    C0_SW = 3'b110
  } c0_funct3_e;

  typedef enum logic [2:0] {
    C1_ADDI = 3'b000,
    C1_LI   = 3'b010,
    C1_LUI  = 3'b011,
    C1_J    = 3'b101,
    C1_BEQZ = 3'b110,
    C1_BNEZ = 3'b111
  } c1_funct3_e;

  // C.MV and C.ADD share this case and differ in bit 12
  typedef enum logic [2:0] {
    C2_MV_ADD = 3'b100
  } c2_funct3_e;

endpackage

`default_nettype wire
